/* hw/gamePkg.sv */
// ******************
// coordinates and sizes are unsigned 10-bit pixels, keycodes are USB HID usage ids
// motion values share coordT and are read as two's complement
// ******************
`default_nettype none

package gamePkg;

    // screen coordinate or size in pixels
    typedef logic [9:0] coordT;

    // raw keyboard keycode as delivered by the host side
    typedef logic [7:0] keyCodeT;

    // collisions since reset, wraps at 255
    typedef logic [7:0] hitCountT;

    // direction keys, HID usage ids of W S A D
    // w, up
    localparam keyCodeT keyUp = 8'h1A;
    // s, down
    localparam keyCodeT keyDown = 8'h16;
    // a, left
    localparam keyCodeT keyLeft = 8'h04;
    // d, right
    localparam keyCodeT keyRight = 8'h07;

    // nothing held
    localparam keyCodeT keyNone = 8'h00;

endpackage

`default_nettype wire

/* hw/ballMotion.sv */
// ******************
// position freezes while no key is held, hit returns the ball to its start
// edge tests use 10-bit wrapping sums, so the start must lie inside the bounds
// ******************
`timescale 1ns/10ps
`default_nettype none

module ballMotion #(
    parameter gamePkg::coordT xMin       = 0,
    parameter gamePkg::coordT xMax       = 639,
    parameter gamePkg::coordT yMin       = 0,
    parameter gamePkg::coordT yMax       = 479,
    parameter gamePkg::coordT ballSize   = 16,
    parameter gamePkg::coordT ballStep   = 1,
    parameter gamePkg::coordT ballStartX = 30,
    parameter gamePkg::coordT ballStartY = 240
) (
    input  logic             frame_clk,
    input  logic             rstN,
    input  gamePkg::keyCodeT keycode,
    input  logic             hit,
    output gamePkg::coordT   ballX,
    output gamePkg::coordT   ballY
);

    import gamePkg::*;

    // unit motion set by the direction keys
    localparam coordT motionPos = 10'd1;
    localparam coordT motionNeg = 10'h3FF;
    // bounce step toward the screen centre, two's complement
    localparam coordT stepNeg = 10'd0 - ballStep;

    // motion registers, two's complement per axis
    coordT motionX;
    coordT motionY;
    coordT nextMotionX;
    coordT nextMotionY;

    // box edges of the ball
    coordT xHigh;
    coordT xLow;
    coordT yHigh;
    coordT yLow;

    coordT nextX;
    coordT nextY;

    assign xHigh = ballX + ballSize;
    assign xLow  = ballX - ballSize;
    assign yHigh = ballY + ballSize;
    assign yLow  = ballY - ballSize;

    always_comb
    begin
        // keep going the same way by default
        nextMotionX = motionX;
        nextMotionY = motionY;

        // a direction key replaces the motion, one axis at a time
        case (keycode)
            keyUp:
            begin
                nextMotionY = motionNeg;
                nextMotionX = '0;
            end
            keyDown:
            begin
                nextMotionY = motionPos;
                nextMotionX = '0;
            end
            keyLeft:
            begin
                nextMotionX = motionNeg;
                nextMotionY = '0;
            end
            keyRight:
            begin
                nextMotionX = motionPos;
                nextMotionY = '0;
            end
            default:
            begin
                nextMotionX = motionX;
                nextMotionY = motionY;
            end
        endcase

        // edges win over the key, each axis on its own
        if (yHigh >= yMax)
            nextMotionY = stepNeg;
        else if (yLow <= yMin)
            nextMotionY = ballStep;

        if (xHigh >= xMax)
            nextMotionX = stepNeg;
        else if (xLow <= xMin)
            nextMotionX = ballStep;
    end

    // wrapping add doubles as signed add
    assign nextX = ballX + nextMotionX;
    assign nextY = ballY + nextMotionY;

    always_ff @(posedge frame_clk or negedge rstN)
    begin
        if (!rstN)
        begin
            motionX <= '0;
            motionY <= '0;
            ballX   <= ballStartX;
            ballY   <= ballStartY;
        end
        else if (hit)
        begin
            // back to start, standing still
            motionX <= '0;
            motionY <= '0;
            ballX   <= ballStartX;
            ballY   <= ballStartY;
        end
        else if (keycode != keyNone)
        begin
            motionX <= nextMotionX;
            motionY <= nextMotionY;
            ballX   <= nextX;
            ballY   <= nextY;
        end
    end

endmodule

`default_nettype wire

/* hw/obstacleMotion.sv */
// ******************
// free-running box, never stops and ignores collisions
// start and step should keep the edge tests from wrapping below zero
// ******************
`timescale 1ns/10ps
`default_nettype none

module obstacleMotion #(
    parameter gamePkg::coordT xMin      = 0,
    parameter gamePkg::coordT xMax      = 639,
    parameter gamePkg::coordT yMin      = 0,
    parameter gamePkg::coordT yMax      = 479,
    parameter gamePkg::coordT obsSize   = 8,
    parameter gamePkg::coordT obsStep   = 2,
    parameter gamePkg::coordT obsStartX = 150,
    parameter gamePkg::coordT obsStartY = 350
) (
    input  logic           frame_clk,
    input  logic           rstN,
    output gamePkg::coordT obsX,
    output gamePkg::coordT obsY
);

    import gamePkg::*;

    // step back toward the centre, two's complement
    localparam coordT stepNeg = 10'd0 - obsStep;

    coordT motionX;
    coordT motionY;
    coordT nextMotionX;
    coordT nextMotionY;

    // box edges
    coordT xHigh;
    coordT xLow;
    coordT yHigh;
    coordT yLow;

    assign xHigh = obsX + obsSize;
    assign xLow  = obsX - obsSize;
    assign yHigh = obsY + obsSize;
    assign yLow  = obsY - obsSize;

    always_comb
    begin
        nextMotionX = motionX;
        nextMotionY = motionY;

        // same bounce rule as the ball
        if (yHigh >= yMax)
            nextMotionY = stepNeg;
        else if (yLow <= yMin)
            nextMotionY = obsStep;

        if (xHigh >= xMax)
            nextMotionX = stepNeg;
        else if (xLow <= xMin)
            nextMotionX = obsStep;
    end

    always_ff @(posedge frame_clk or negedge rstN)
    begin
        if (!rstN)
        begin
            // starts heading down-right
            motionX <= obsStep;
            motionY <= obsStep;
            obsX    <= obsStartX;
            obsY    <= obsStartY;
        end
        else
        begin
            motionX <= nextMotionX;
            motionY <= nextMotionY;
            obsX    <= obsX + nextMotionX;
            obsY    <= obsY + nextMotionY;
        end
    end

endmodule

`default_nettype wire

/* hw/collisionCheck.sv */
// ******************
// hit is one frame late and gives one pulse per overlap episode
// hitCount wraps at 255
// ******************
`timescale 1ns/10ps
`default_nettype none

module collisionCheck #(
    parameter gamePkg::coordT ballSize = 16,
    parameter gamePkg::coordT obsSize  = 8
) (
    input  logic              frame_clk,
    input  logic              rstN,
    input  gamePkg::coordT    ballX,
    input  gamePkg::coordT    ballY,
    input  gamePkg::coordT    obsX,
    input  gamePkg::coordT    obsY,
    output logic              hit,
    output gamePkg::hitCountT hitCount
);

    import gamePkg::*;

    // centre distance below which the boxes touch
    localparam coordT reach = ballSize + obsSize;

    coordT distX;
    coordT distY;
    logic  overlap;
    logic  setHit;

    // absolute differences, no sign needed
    assign distX = (ballX >= obsX) ? (ballX - obsX) : (obsX - ballX);
    assign distY = (ballY >= obsY) ? (ballY - obsY) : (obsY - ballY);

    assign overlap = (distX < reach) && (distY < reach);

    // the ball is still overlapping in the hit cycle, so mask it there
    assign setHit = overlap && !hit;

    always_ff @(posedge frame_clk or negedge rstN)
    begin
        if (!rstN)
        begin
            hit      <= 1'b0;
            hitCount <= '0;
        end
        else
        begin
            hit <= setHit;
            if (setHit)
                hitCount <= hitCount + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/gameTop.sv */
// ******************
// one frame_clk edge per video frame
// keycode is sampled as a level, no keyboard interface here
// ******************
`timescale 1ns/10ps
`default_nettype none

module gameTop #(
    // screen bounds
    parameter gamePkg::coordT xMin       = 0,
    parameter gamePkg::coordT xMax       = 639,
    parameter gamePkg::coordT yMin       = 0,
    parameter gamePkg::coordT yMax       = 479,
    // player ball
    parameter gamePkg::coordT ballSize   = 16,
    parameter gamePkg::coordT ballStep   = 1,
    parameter gamePkg::coordT ballStartX = 30,
    parameter gamePkg::coordT ballStartY = 240,
    // obstacle
    parameter gamePkg::coordT obsSize    = 8,
    parameter gamePkg::coordT obsStep    = 2,
    parameter gamePkg::coordT obsStartX  = 150,
    parameter gamePkg::coordT obsStartY  = 350
) (
    input  logic              frame_clk,
    input  logic              rstN,
    input  gamePkg::keyCodeT  keycode,
    output gamePkg::coordT    ballX,
    output gamePkg::coordT    ballY,
    output gamePkg::coordT    obsX,
    output gamePkg::coordT    obsY,
    output logic              hit,
    output gamePkg::hitCountT hitCount
);

    // player, steered by keys, sent home on hit
    ballMotion #(
        .xMin(xMin), .xMax(xMax), .yMin(yMin), .yMax(yMax),
        .ballSize(ballSize), .ballStep(ballStep),
        .ballStartX(ballStartX), .ballStartY(ballStartY)
    ) ball (
        .frame_clk(frame_clk),
        .rstN(rstN),
        .keycode(keycode),
        .hit(hit),
        .ballX(ballX),
        .ballY(ballY)
    );

    // wandering obstacle
    obstacleMotion #(
        .xMin(xMin), .xMax(xMax), .yMin(yMin), .yMax(yMax),
        .obsSize(obsSize), .obsStep(obsStep),
        .obsStartX(obsStartX), .obsStartY(obsStartY)
    ) obstacle (
        .frame_clk(frame_clk),
        .rstN(rstN),
        .obsX(obsX),
        .obsY(obsY)
    );

    // overlap test, hit feeds back into the ball
    collisionCheck #(
        .ballSize(ballSize),
        .obsSize(obsSize)
    ) collide (
        .frame_clk(frame_clk),
        .rstN(rstN),
        .ballX(ballX),
        .ballY(ballY),
        .obsX(obsX),
        .obsY(obsY),
        .hit(hit),
        .hitCount(hitCount)
    );

endmodule

`default_nettype wire

/* testbench/gameTb.sv */
// ********************
// directed tests against a frame-by-frame model of the ball, obstacle and hit rules
// model parameters are copies of the gameTop defaults and must track them
// ********************
`timescale 1ns/10ps
`default_nettype none

module gameTb;

    import gamePkg::*;

    // own copies of the game parameters
    localparam int xMin = 0;
    localparam int xMax = 639;
    localparam int yMin = 0;
    localparam int yMax = 479;
    localparam int ballSize = 16;
    localparam int ballStep = 1;
    localparam int ballStartX = 30;
    localparam int ballStartY = 240;
    localparam int obsSize = 8;
    localparam int obsStep = 2;
    localparam int obsStartX = 150;
    localparam int obsStartY = 350;

    // farthest the obstacle gets past an edge before it turns
    localparam int obsLoX = xMin + obsSize - obsStep + 1;
    localparam int obsHiX = xMax - obsSize + obsStep - 1;
    localparam int obsLoY = yMin + obsSize - obsStep + 1;
    localparam int obsHiY = yMax - obsSize + obsStep - 1;

    // test lengths in frames
    localparam int resetCycles = 4;
    localparam int steerCycles = 110;
    localparam int edgeCycles = 45;
    localparam int obsCycles = 600;
    localparam int collideWait = 400;
    localparam int collideCycles = 300 + collideWait + 4;
    localparam int randomCycles = 1500;
    localparam int timeoutCycles = 4 * resetCycles + steerCycles + edgeCycles + obsCycles
        + collideCycles + randomCycles + 100;

    logic      frame_clk;
    logic      rstN;
    keyCodeT   keycode;
    coordT     ballX;
    coordT     ballY;
    coordT     obsX;
    coordT     obsY;
    logic      hit;
    hitCountT  hitCount;

    // reference state
    int      mBallX;
    int      mBallY;
    int      mMotX;
    int      mMotY;
    int      mObsX;
    int      mObsY;
    int      mObsMotX;
    int      mObsMotY;
    bit      mHit;
    int      mHitCount;
    // key on the bus for the next edge
    keyCodeT curKey;

    int      cycleCount;
    integer  seed;

    gameTop uut (
        .frame_clk(frame_clk),
        .rstN(rstN),
        .keycode(keycode),
        .ballX(ballX),
        .ballY(ballY),
        .obsX(obsX),
        .obsY(obsY),
        .hit(hit),
        .hitCount(hitCount)
    );

    initial
    begin
        frame_clk = 1'b0;
        forever
            #4 frame_clk = ~frame_clk;
    end

    // run limit
    always @(posedge frame_clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles)
        begin
            $display("Timeout: run did not finish within %0d frames", timeoutCycles);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic compareValue(input string name, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            $display("Fail at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkTrue(input bit cond, input string what);
        assert (cond)
        else
        begin
            $display("Error at %0t: %s", $time, what);
            $display("Result: FAILED");
            $fatal(1, "check failed");
        end
    endtask

    function automatic int absDiff(input int a, input int b);
        return (a >= b) ? a - b : b - a;
    endfunction

    function automatic bit boxesOverlap(input int bx, input int by, input int ox, input int oy);
        return (absDiff(bx, ox) < ballSize + obsSize) && (absDiff(by, oy) < ballSize + obsSize);
    endfunction

    // edge rule for one axis
    // top edge is tested first
    function automatic int bounceMotion(input int pos, input int size, input int lo,
                                        input int hi, input int step, input int mot);
        if (pos + size >= hi)
            return -step;
        else if (pos - size <= lo)
            return step;
        return mot;
    endfunction

    task automatic modelReset();
        mBallX = ballStartX;
        mBallY = ballStartY;
        mMotX = 0;
        mMotY = 0;
        mObsX = obsStartX;
        mObsY = obsStartY;
        mObsMotX = obsStep;
        mObsMotY = obsStep;
        mHit = 1'b0;
        mHitCount = 0;
    endtask

    // one frame from the state before the edge
    task automatic modelStep(input keyCodeT k);
        int nmX;
        int nmY;
        bit newHit;
        newHit = boxesOverlap(mBallX, mBallY, mObsX, mObsY) && !mHit;
        nmX = mMotX;
        nmY = mMotY;
        if (k == keyUp)
        begin
            nmY = -1;
            nmX = 0;
        end
        else if (k == keyDown)
        begin
            nmY = 1;
            nmX = 0;
        end
        else if (k == keyLeft)
        begin
            nmX = -1;
            nmY = 0;
        end
        else if (k == keyRight)
        begin
            nmX = 1;
            nmY = 0;
        end
        nmY = bounceMotion(mBallY, ballSize, yMin, yMax, ballStep, nmY);
        nmX = bounceMotion(mBallX, ballSize, xMin, xMax, ballStep, nmX);
        if (mHit)
        begin
            mBallX = ballStartX;
            mBallY = ballStartY;
            mMotX = 0;
            mMotY = 0;
        end
        else if (k != keyNone)
        begin
            mMotX = nmX;
            mMotY = nmY;
            mBallX = mBallX + nmX;
            mBallY = mBallY + nmY;
        end
        // obstacle never stops
        mObsMotY = bounceMotion(mObsY, obsSize, yMin, yMax, obsStep, mObsMotY);
        mObsMotX = bounceMotion(mObsX, obsSize, xMin, xMax, obsStep, mObsMotX);
        mObsX = mObsX + mObsMotX;
        mObsY = mObsY + mObsMotY;
        if (newHit)
            mHitCount = (mHitCount + 1) % 256;
        mHit = newHit;
    endtask

    task automatic checkOutputs();
        compareValue("ballX", mBallX, int'(ballX));
        compareValue("ballY", mBallY, int'(ballY));
        compareValue("obsX", mObsX, int'(obsX));
        compareValue("obsY", mObsY, int'(obsY));
        compareValue("hit", int'(mHit), int'(hit));
        compareValue("hitCount", mHitCount, int'(hitCount));
    endtask

    // k goes on the bus now and is used at the following edge
    task automatic runCycle(input keyCodeT k);
        @(posedge frame_clk);
        modelStep(curKey);
        keycode <= k;
        curKey = k;
        // outputs settled by the falling edge
        @(negedge frame_clk);
        checkOutputs();
    endtask

    task automatic applyReset();
        @(posedge frame_clk);
        rstN <= 1'b0;
        keycode <= keyNone;
        curKey = keyNone;
        repeat (2)
            @(posedge frame_clk);
        rstN <= 1'b1;
        modelReset();
        @(negedge frame_clk);
        checkOutputs();
    endtask

    task automatic resetState();
        applyReset();
        compareValue("ballX", ballStartX, int'(ballX));
        compareValue("ballY", ballStartY, int'(ballY));
        compareValue("hitCount", 0, int'(hitCount));
        repeat (20)
            runCycle(keyRight);
        // mid-run reset must give the same start
        applyReset();
        compareValue("ballX", ballStartX, int'(ballX));
        compareValue("obsY", obsStartY, int'(obsY));
        compareValue("hit", 0, int'(hit));
    endtask

    task automatic steerAndFreeze();
        int prevX;
        int prevY;
        int prevObsX;
        runCycle(keyRight);
        repeat (40)
        begin
            prevX = int'(ballX);
            runCycle(keyRight);
            compareValue("ballX", prevX + 1, int'(ballX));
        end
        runCycle(keyUp);
        repeat (30)
        begin
            prevY = int'(ballY);
            runCycle(keyUp);
            compareValue("ballY", prevY - 1, int'(ballY));
        end
        // ball holds with no key while the obstacle keeps going
        runCycle(keyNone);
        repeat (20)
        begin
            prevX = int'(ballX);
            prevY = int'(ballY);
            prevObsX = int'(obsX);
            runCycle(keyNone);
            compareValue("ballX", prevX, int'(ballX));
            compareValue("ballY", prevY, int'(ballY));
            checkTrue(int'(obsX) != prevObsX, "obstacle stopped while the ball was frozen");
        end
        // space bar keeps the last direction up
        runCycle(8'h2C);
        repeat (10)
        begin
            prevY = int'(ballY);
            runCycle(8'h2C);
            compareValue("ballY", prevY - 1, int'(ballY));
        end
    endtask

    task automatic ballEdgeBounce();
        int minX;
        int prevX;
        int rises;
        applyReset();
        minX = int'(ballX);
        rises = 0;
        repeat (40)
        begin
            prevX = int'(ballX);
            runCycle(keyLeft);
            if (int'(ballX) < minX)
                minX = int'(ballX);
            if (int'(ballX) > prevX)
                rises++;
        end
        compareValue("ballX", xMin + ballSize, minX);
        checkTrue(rises > 0, "ball never turned back at the left edge");
    endtask

    task automatic obstacleBounce();
        int prevX;
        int prevY;
        int dirX;
        int dirY;
        int turnsX;
        int turnsY;
        dirX = obsStep;
        dirY = obsStep;
        turnsX = 0;
        turnsY = 0;
        repeat (obsCycles)
        begin
            prevX = int'(obsX);
            prevY = int'(obsY);
            runCycle(keyNone);
            checkTrue(int'(obsX) >= obsLoX && int'(obsX) <= obsHiX,
                "obstacle went past its turning range in x");
            checkTrue(int'(obsY) >= obsLoY && int'(obsY) <= obsHiY,
                "obstacle went past its turning range in y");
            if ((int'(obsX) - prevX) != dirX)
                turnsX++;
            if ((int'(obsY) - prevY) != dirY)
                turnsY++;
            dirX = int'(obsX) - prevX;
            dirY = int'(obsY) - prevY;
        end
        checkTrue(turnsX > 0, "obstacle never reversed in x");
        checkTrue(turnsY > 0, "obstacle never reversed in y");
    endtask

    task automatic collideWithObstacle();
        int countBefore;
        int waited;
        bit overlapBefore;
        applyReset();
        // park the ball on the obstacle's rising diagonal x + y = 536
        while (mBallX < 200)
            runCycle(keyRight);
        while (mBallY < 336)
            runCycle(keyDown);
        runCycle(keyNone);
        countBefore = int'(hitCount);
        waited = 0;
        overlapBefore = 1'b0;
        while (!hit && waited < collideWait)
        begin
            // overlap as seen on the DUT outputs before the edge
            overlapBefore = boxesOverlap(int'(ballX), int'(ballY), int'(obsX), int'(obsY));
            runCycle(keyNone);
            waited++;
        end
        checkTrue(hit, "no collision within the wait window");
        checkTrue(overlapBefore, "hit without overlap in the frame before");
        compareValue("hitCount", countBefore + 1, int'(hitCount));
        // two frames after the overlap the ball is home
        runCycle(keyNone);
        compareValue("ballX", ballStartX, int'(ballX));
        compareValue("ballY", ballStartY, int'(ballY));
        compareValue("hit", 0, int'(hit));
    endtask

    function automatic keyCodeT pickKey(input int idx);
        case (idx)
            0: return keyUp;
            1: return keyDown;
            2: return keyLeft;
            3: return keyRight;
            4: return keyNone;
            default: return 8'h2C;
        endcase
    endfunction

    task automatic randomPlay();
        int idx;
        repeat (randomCycles)
        begin
            idx = int'($unsigned($random(seed)) % 6);
            runCycle(pickKey(idx));
        end
    endtask

    initial
    begin
        rstN <= 1'b0;
        keycode <= keyNone;
        curKey = keyNone;
        cycleCount = 0;
        seed = 32'h85c3;
        modelReset();
        resetState();
        steerAndFreeze();
        ballEdgeBounce();
        obstacleBounce();
        collideWithObstacle();
        randomPlay();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hw/gamePkg.sv
hw/ballMotion.sv
hw/obstacleMotion.sv
hw/collisionCheck.sv
hw/gameTop.sv
testbench/gameTb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it
# exit status is nonzero when the build fails or the run ends in $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module gameTb -Mdir obj_dir -o gameSim &&
./obj_dir/gameSim ||
{
    echo "simulation failed"
    exit 1
}
